/* hdl/dnc_fixed_pkg.sv */
// Fixed-point element format and sigmoid segment constants
// Shared by the erase-vector datapath stages and the top level
package dnc_fixed_pkg;

  // Q8.8 element word
  localparam int element_width = 16;
  localparam int fraction_bits = 8;

  // One element word, decoded either as a number or as its fields
  typedef union packed {
    logic signed [element_width-1:0] raw;
    struct packed {
      logic                     sign;
      logic [6:0]               integer_part;
      logic [fraction_bits-1:0] fraction;
    } fields;
  } fixed_element_t;

  // Approximation segments, ordered by magnitude
  typedef enum logic [1:0] {
    seg_linear,
    seg_mid,
    seg_tail,
    seg_saturate
  } segment_t;

  ////////////////////////////////////////
  // Segment constants
  ////////////////////////////////////////

  localparam logic [element_width-1:0] fixed_one = element_width'(1 << fraction_bits);

  // Breakpoints 1.0, 2.375 (19/8) and 5.0
  localparam logic [element_width-1:0] breakpoint_mid  = fixed_one;
  localparam logic [element_width-1:0] breakpoint_tail = element_width'(19 << (fraction_bits - 3));
  localparam logic [element_width-1:0] breakpoint_sat  = element_width'(5 << fraction_bits);

  // Offsets 0.5, 0.625 (5/8) and 0.84375 (27/32)
  localparam logic [element_width-1:0] offset_linear = element_width'(1 << (fraction_bits - 1));
  localparam logic [element_width-1:0] offset_mid    = element_width'(5 << (fraction_bits - 3));
  localparam logic [element_width-1:0] offset_tail   = element_width'(27 << (fraction_bits - 5));

  // Slopes 1/4, 1/8 and 1/32 as right shifts
  localparam logic [element_width-1:0] shift_linear = 16'd2;
  localparam logic [element_width-1:0] shift_mid    = 16'd3;
  localparam logic [element_width-1:0] shift_tail   = 16'd5;

endpackage

/* hdl/dnc_control_pkg.sv */
// Vector sequencing types for the erase-vector control FSM
// Imported by the control module
package dnc_control_pkg;

  ////////////////////////////////////////
  // Vector sequencing
  ////////////////////////////////////////

  // Idle waits for start, ready high
  // Stream accepts elements until W have entered
  // Drain waits for the pipeline to emit all W results
  typedef enum logic [1:0] {
    idle,
    stream,
    drain
  } vector_state_t;

endpackage

/* hdl/dnc_vector_control.sv */
// Control FSM of the erase-vector unit
// Opens a vector on start, counts accepted and emitted elements, drives ready
module dnc_vector_control import dnc_control_pkg::*; #(
  parameter int size_width = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  e_in_enable,
  input  logic                  out_enable,
  input  logic [size_width-1:0] size_w_in,
  output logic                  ready,
  output logic                  accept
);

  vector_state_t state;

  // Latched W of the open vector
  logic [size_width-1:0] size_w;

  // Separate counts for elements in and results out
  logic [size_width-1:0] accept_count;
  logic [size_width-1:0] emit_count;
  logic [size_width-1:0] accept_next;
  logic [size_width-1:0] emit_next;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Enables outside the stream state are dropped
  assign accept = e_in_enable && (state == stream);

  // Ready only once the vector has fully drained
  assign ready = (state == idle);

  // Counts including this cycle's event
  assign accept_next = accept_count + size_width'(accept);
  assign emit_next   = emit_count + size_width'(out_enable);

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= idle;
      size_w       <= '0;
      accept_count <= '0;
      emit_count   <= '0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            size_w       <= size_w_in;
            accept_count <= '0;
            emit_count   <= '0;
            // Empty vector skips straight to drain, one cycle busy
            state <= (size_w_in == '0) ? drain : stream;
          end
        end
        stream: begin
          accept_count <= accept_next;
          // Earlier elements may already be leaving the pipeline
          emit_count   <= emit_next;
          if (accept_next == size_w) begin
            state <= drain;
          end
        end
        drain: begin
          emit_count <= emit_next;
          // Last result out this cycle, ready next cycle
          if (emit_next == size_w) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* hdl/ntm_logistic_segment.sv */
// First sigmoid pipeline stage
// Takes the magnitude of the input and picks its approximation segment
module ntm_logistic_segment import dnc_fixed_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     accept,
  input  fixed_element_t           e_in,
  output logic                     stage_valid,
  output logic                     stage_sign,
  output segment_t                 stage_segment,
  output logic [element_width-1:0] stage_magnitude
);

  // Most negative word has no positive twin
  localparam logic [element_width-1:0] most_negative = {1'b1, {(element_width-1){1'b0}}};
  localparam logic [element_width-1:0] max_positive  = {1'b0, {(element_width-1){1'b1}}};

  logic [element_width-1:0] magnitude;
  segment_t                 segment;

  ////////////////////////////////////////
  // Magnitude and segment select
  ////////////////////////////////////////

  always_comb begin
    if (!e_in.fields.sign) begin
      magnitude = e_in.raw;
    end else if (e_in.raw == most_negative) begin
      // Clamp, result saturates anyway
      magnitude = max_positive;
    end else begin
      magnitude = -e_in.raw;
    end
  end

  // Breakpoints are ascending
  always_comb begin
    if (magnitude < breakpoint_mid) begin
      segment = seg_linear;
    end else if (magnitude < breakpoint_tail) begin
      segment = seg_mid;
    end else if (magnitude < breakpoint_sat) begin
      segment = seg_tail;
    end else begin
      segment = seg_saturate;
    end
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= accept;
    end
  end

  // Payload moves only with an accepted element
  always_ff @(posedge clk) begin
    if (accept) begin
      stage_sign      <= e_in.fields.sign;
      stage_segment   <= segment;
      stage_magnitude <= magnitude;
    end
  end

endmodule

/* hdl/ntm_logistic_shift_add.sv */
// Second sigmoid pipeline stage
// Shift-and-add on the positive side, then mirror for negative inputs
module ntm_logistic_shift_add import dnc_fixed_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stage_valid,
  input  logic                     stage_sign,
  input  segment_t                 stage_segment,
  input  logic [element_width-1:0] stage_magnitude,
  output logic                     out_enable,
  output logic [element_width-1:0] e_out
);

  // Sigmoid of the magnitude, never above one
  logic [element_width-1:0] positive_result;
  logic [element_width-1:0] signed_result;

  ////////////////////////////////////////
  // Shift and add
  ////////////////////////////////////////

  always_comb begin
    case (stage_segment)
      seg_linear: begin
        positive_result = (stage_magnitude >> shift_linear) + offset_linear;
      end
      seg_mid: begin
        positive_result = (stage_magnitude >> shift_mid) + offset_mid;
      end
      seg_tail: begin
        positive_result = (stage_magnitude >> shift_tail) + offset_tail;
      end
      default: begin
        // Saturated, pinned to one
        positive_result = fixed_one;
      end
    endcase
  end

  // sigmoid(-x) = 1 - sigmoid(x)
  assign signed_result = stage_sign ? (fixed_one - positive_result) : positive_result;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_enable <= 1'b0;
      e_out      <= '0;
    end else begin
      out_enable <= stage_valid;
      // Hold last result between enables
      if (stage_valid) begin
        e_out <= signed_result;
      end
    end
  end

endmodule

/* hdl/dnc_erase_vector.sv */
// Erase-vector unit, e(t;k) = sigmoid(e^(t;k)) for k in 0 to W-1
// Control FSM plus a two-stage sigmoid pipeline, latency two cycles
module dnc_erase_vector import dnc_fixed_pkg::*; #(
  parameter int size_width = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  output logic                     ready,
  input  logic                     e_in_enable,
  output logic                     e_out_enable,
  input  logic [size_width-1:0]    size_w_in,
  input  logic [element_width-1:0] e_in,
  output logic [element_width-1:0] e_out
);

  // Element taken in the stream state
  logic accept;

  // Stage one to stage two
  logic                     stage_valid;
  logic                     stage_sign;
  segment_t                 stage_segment;
  logic [element_width-1:0] stage_magnitude;

  // Emitted results also feed back to the emit counter
  dnc_vector_control #(
    .size_width (size_width)
  ) control_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .e_in_enable (e_in_enable),
    .out_enable  (e_out_enable),
    .size_w_in   (size_w_in),
    .ready       (ready),
    .accept      (accept)
  );

  ntm_logistic_segment segment_i (
    .clk             (clk),
    .reset           (reset),
    .accept          (accept),
    .e_in            (e_in),
    .stage_valid     (stage_valid),
    .stage_sign      (stage_sign),
    .stage_segment   (stage_segment),
    .stage_magnitude (stage_magnitude)
  );

  ntm_logistic_shift_add shift_add_i (
    .clk             (clk),
    .reset           (reset),
    .stage_valid     (stage_valid),
    .stage_sign      (stage_sign),
    .stage_segment   (stage_segment),
    .stage_magnitude (stage_magnitude),
    .out_enable      (e_out_enable),
    .e_out           (e_out)
  );

endmodule

/* verif/dnc_erase_vector_assertions.sv */
// Bound checker for the erase-vector unit
// Models the sigmoid approximation and checks values, latency and the handshake
module dnc_erase_vector_assertions import dnc_fixed_pkg::*; (
  input logic                     clk,
  input logic                     reset,
  input logic                     start,
  input logic                     ready,
  input logic                     e_in_enable,
  input logic                     e_out_enable,
  input logic                     accept,
  input logic [element_width-1:0] e_in,
  input logic [element_width-1:0] e_out
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int assertion_errors = 0;

  // Inputs of the elements now leaving the pipeline
  logic [element_width-1:0] e_in_d1;
  logic [element_width-1:0] e_in_d2;

  // Piecewise-linear sigmoid in Q8.8, mirrored for negative inputs
  function automatic logic [element_width-1:0] expected_sigmoid(logic [element_width-1:0] x);
    int value;
    int mag;
    int y;
    value = int'($signed(x));
    mag = (value < 0) ? -value : value;
    // Most negative word has no positive twin
    if (mag > 32767) begin
      mag = 32767;
    end
    if (mag < 256) begin
      y = 128 + (mag >>> 2);
    end else if (mag < 608) begin
      y = 160 + (mag >>> 3);
    end else if (mag < 1280) begin
      y = 216 + (mag >>> 5);
    end else begin
      y = 256;
    end
    if (value < 0) begin
      y = 256 - y;
    end
    return 16'(y);
  endfunction

  always_ff @(posedge clk) begin
    e_in_d1 <= e_in;
    e_in_d2 <= e_in_d1;
  end

  ////////////////////////////////////////
  // Reset and handshake
  ////////////////////////////////////////

  reset_state_a: assert property (@(posedge clk)
      $fell(reset) |-> ready && !e_out_enable && e_out == '0) else begin
    $error("FAIL after reset: ready %h, e_out_enable %h, e_out %h",
           $sampled(ready), $sampled(e_out_enable), $sampled(e_out));
    assertion_errors++;
  end

  start_busy_a: assert property (@(posedge clk) disable iff (reset)
      start && ready |=> !ready) else begin
    $error("ready stayed high after an accepted start");
    assertion_errors++;
  end

  // Last output one cycle earlier, or an empty vector
  ready_rise_a: assert property (@(posedge clk) disable iff (reset)
      $rose(ready) |-> $past(e_out_enable) || $past(start, 2)) else begin
    $error("ready returned without a final output");
    assertion_errors++;
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  latency_a: assert property (@(posedge clk) disable iff (reset)
      e_out_enable == $past(accept, 2)) else begin
    $error("Output enable not two cycles after an accepted element");
    assertion_errors++;
  end

  // Enable with no open vector gives no output
  stray_enable_a: assert property (@(posedge clk) disable iff (reset)
      $past(e_in_enable && ready, 2) |-> !e_out_enable) else begin
    $error("Output appeared for an enable outside a vector");
    assertion_errors++;
  end

  value_a: assert property (@(posedge clk) disable iff (reset)
      e_out_enable |-> e_out == expected_sigmoid($past(e_in, 2))) else begin
    $error("FAIL e_out: expected %h, got %h",
           expected_sigmoid($sampled(e_in_d2)), $sampled(e_out));
    assertion_errors++;
  end

  bound_a: assert property (@(posedge clk) disable iff (reset)
      e_out_enable |-> e_out <= fixed_one) else begin
    $error("FAIL e_out: %h above one", $sampled(e_out));
    assertion_errors++;
  end

  // Back-to-back x and -x must sum to one
  symmetry_a: assert property (@(posedge clk) disable iff (reset)
      e_out_enable && $past(e_out_enable) && $past(e_in, 2) != 16'h8000
      && ($past(e_in, 2) + $past(e_in, 3)) == 16'h0000
      |-> {1'b0, e_out} + {1'b0, $past(e_out)} == 17'h00100) else begin
    $error("Results for x and -x do not sum to one");
    assertion_errors++;
  end

endmodule

bind dnc_erase_vector dnc_erase_vector_assertions checks_i (.*);

/* verif/tb_dnc_erase_vector.sv */
// Testbench for the erase-vector unit
// Corner vectors first, then random vectors with gaps; values are checked by the bound assertions
module tb_dnc_erase_vector;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        reset;
  logic        start;
  logic        ready;
  logic        e_in_enable;
  logic        e_out_enable;
  logic [7:0]  size_w_in;
  logic [15:0] e_in;
  logic [15:0] e_out;

  int seed = 98274;
  int error_count = 0;
  int timeout_count = 0;
  int total_outputs = 0;

  // Elements of the vector being sent
  logic [15:0] vector_values[$];

  dnc_erase_vector #(.size_width(8)) dut_i (.*);

  always #4 clk = ~clk;

  // Every output pulse, inside a vector or not
  always @(posedge clk) begin
    if (!reset && e_out_enable) begin
      total_outputs <= total_outputs + 1;
    end
  end

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("Timeout: ready did not return after a vector");
      timeout_count++;
    end
  endtask

  // Enable with no open vector, must be dropped
  task automatic pulse_stray_enable();
    e_in = 16'($random(seed));
    e_in_enable = 1'b1;
    @(negedge clk);
    e_in_enable = 1'b0;
  endtask

  task automatic send_vector(input int max_gap);
    int base;
    int gap;
    wait_ready();
    base = total_outputs;
    if (max_gap > 0 && {$random(seed)} % 4 == 0) begin
      pulse_stray_enable();
    end
    start = 1'b1;
    size_w_in = 8'(vector_values.size());
    @(negedge clk);
    start = 1'b0;
    foreach (vector_values[i]) begin
      gap = (max_gap > 0) ? int'({$random(seed)} % (max_gap + 1)) : 0;
      repeat (gap) @(negedge clk);
      e_in = vector_values[i];
      e_in_enable = 1'b1;
      @(negedge clk);
      e_in_enable = 1'b0;
    end
    pulse_stray_enable();
    wait_ready();
    if (total_outputs - base != vector_values.size()) begin
      $display("FAIL e_out_enable count: expected %h, got %h",
               vector_values.size(), total_outputs - base);
      error_count++;
    end
  endtask

  initial begin
    logic [15:0] raw;
    int w;
    int shift;
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    e_in_enable = 1'b0;
    size_w_in = '0;
    e_in = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (ready !== 1'b1 || e_out_enable !== 1'b0 || e_out !== 16'h0000) begin
      $display("FAIL after reset: ready %h, e_out_enable %h, e_out %h",
               ready, e_out_enable, e_out);
      error_count++;
    end

    // Corners in x, -x pairs: zero, breakpoints, just below them, extremes, fractions
    vector_values = '{16'h0000, 16'h0000, 16'h0100, 16'hff00, 16'h0260, 16'hfda0,
                      16'h025f, 16'hfda1, 16'h0500, 16'hfb00, 16'h04ff, 16'hfb01,
                      16'h7fff, 16'h8001, 16'h0001, 16'hffff, 16'h0080, 16'hff80};
    send_vector(0);
    vector_values = '{16'h8000, 16'h00ff};
    send_vector(0);
    // Empty vector
    vector_values = {};
    send_vector(0);

    ////////////////////////////////////////
    // Random vectors
    ////////////////////////////////////////
    for (int v = 0; v < 30; v++) begin
      vector_values = {};
      w = int'({$random(seed)} % 41);
      for (int i = 0; i < w; i++) begin
        if (i % 2 == 1) begin
          raw = -vector_values[i-1];
        end else begin
          // Shifted down to reach the small segments too
          raw = 16'($random(seed));
          shift = int'({$random(seed)} % 9);
          raw = 16'($signed(raw) >>> shift);
        end
        vector_values.push_back(raw);
      end
      send_vector(v % 4);
    end

    repeat (4) @(negedge clk);
    $display("Errors: %0d testbench, %0d assertion, %0d timeout",
             error_count, dut_i.checks_i.assertion_errors, timeout_count);
    if (error_count == 0 && dut_i.checks_i.assertion_errors == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/dnc_fixed_pkg.sv
hdl/dnc_control_pkg.sv
hdl/dnc_vector_control.sv
hdl/ntm_logistic_segment.sv
hdl/ntm_logistic_shift_add.sv
hdl/dnc_erase_vector.sv
verif/dnc_erase_vector_assertions.sv
verif/tb_dnc_erase_vector.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dnc_erase_vector -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or simulation returned an error"
if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
